// File: test/bridge_patterns.txt
# S valid order insn pc_rdata pc_wdata trap intr rd rd_wdata mstatus_raw mie_raw mcause_raw mscratch mepc
# I idle_cycles | O overflow | R order insn pc_rdata pc_wdata trap intr x_wb x_wdata | C addr data
I 3
O 0
S 1 0000000000000001 00000013 00000100 00000104 0 0 05 0000abcd 00 00000 00 00000000 00000000
R 0000000000000001 00000013 00000100 00000104 0 0 00000020 0000abcd
S 1 0000000000000002 00000073 00000104 00000108 1 0 00 12345678 00 00000 00 00000000 00000000
R 0000000000000002 00000073 00000104 00000108 1 0 00000000 12345678
S 1 0000000000000003 00a00093 00000108 0000010c 0 1 1f deadbeef 00 00000 00 00000000 00000000
R 0000000000000003 00a00093 00000108 0000010c 0 1 80000000 deadbeef
I 4
S 0 0000000000000000 00000000 00000000 00000000 0 0 00 00000000 2d 5a5a5 4b 00000000 00000000
S 1 0000000000000004 30200073 00000200 00000300 0 0 00 00000000 2d 5a5a5 4b 00000000 00000000
R 0000000000000004 30200073 00000200 00000300 0 0 00000000 00000000
C 300 00201808
C 304 a5a50808
C 342 8000000b
I 6
S 0 0000000000000000 00000000 00000000 00000000 0 0 00 00000000 2d 5a5a5 4b 11111111 00000000
S 0 0000000000000000 00000000 00000000 00000000 0 0 00 00000000 2d 5a5a5 4b 22222222 00000000
S 0 0000000000000000 00000000 00000000 00000000 0 0 00 00000000 2d 5a5a5 4b 33333333 00000000
S 1 0000000000000005 34011073 00000300 00000304 0 0 02 33333333 2d 5a5a5 4b 33333333 00000000
R 0000000000000005 34011073 00000300 00000304 0 0 00000004 33333333
C 340 33333333
S 1 0000000000000006 00000013 00000304 00000308 0 0 00 00000000 2d 5a5a5 4b 33333333 00000000
R 0000000000000006 00000013 00000304 00000308 0 0 00000000 00000000
I 4
S 1 0000000000000007 00000013 00000400 00000404 0 0 01 00000001 2d 5a5a5 4b a0000001 b0000001
R 0000000000000007 00000013 00000400 00000404 0 0 00000002 00000001
C 340 a0000001
C 341 b0000001
S 1 0000000000000008 00000013 00000404 00000408 0 0 02 00000002 2d 5a5a5 4b a0000002 b0000002
R 0000000000000008 00000013 00000404 00000408 0 0 00000004 00000002
C 340 a0000002
C 341 b0000002
S 1 0000000000000009 00000013 00000408 0000040c 0 0 03 00000003 2d 5a5a5 4b a0000003 b0000003
R 0000000000000009 00000013 00000408 0000040c 0 0 00000008 00000003
C 340 a0000003
C 341 b0000003
S 1 000000000000000a 00000013 0000040c 00000410 0 0 04 00000004 2d 5a5a5 4b a0000004 b0000004
R 000000000000000a 00000013 0000040c 00000410 0 0 00000010 00000004
C 340 a0000004
C 341 b0000004
I 16
O 0
S 1 000000000000000b 00000013 00000500 00000504 0 0 00 00000000 01 00001 01 c0000001 d0000001
S 1 000000000000000c 00000013 00000504 00000508 0 0 00 00000000 02 00002 02 c0000002 d0000002
S 1 000000000000000d 00000013 00000508 0000050c 0 0 00 00000000 01 00001 01 c0000003 d0000003
S 1 000000000000000e 00000013 0000050c 00000510 0 0 00 00000000 02 00002 02 c0000004 d0000004
S 1 000000000000000f 00000013 00000510 00000514 0 0 00 00000000 01 00001 01 c0000005 d0000005
S 1 0000000000000010 00000013 00000514 00000518 0 0 00 00000000 02 00002 02 c0000006 d0000006
S 1 0000000000000011 00000013 00000518 0000051c 0 0 00 00000000 01 00001 01 c0000007 d0000007
S 1 0000000000000012 00000013 0000051c 00000520 0 0 00 00000000 02 00002 02 c0000008 d0000008
# Records 0x10 to 0x12 meet a full FIFO and are dropped
R 000000000000000b 00000013 00000500 00000504 0 0 00000000 00000000
C 300 00200000
C 304 00010000
C 342 00000001
C 340 c0000001
C 341 d0000001
R 000000000000000c 00000013 00000504 00000508 0 0 00000000 00000000
C 300 00020000
C 304 00020000
C 342 00000002
C 340 c0000002
C 341 d0000002
R 000000000000000d 00000013 00000508 0000050c 0 0 00000000 00000000
C 300 00200000
C 304 00010000
C 342 00000001
C 340 c0000003
C 341 d0000003
R 000000000000000e 00000013 0000050c 00000510 0 0 00000000 00000000
C 300 00020000
C 304 00020000
C 342 00000002
C 340 c0000004
C 341 d0000004
R 000000000000000f 00000013 00000510 00000514 0 0 00000000 00000000
C 300 00200000
C 304 00010000
C 342 00000001
C 340 c0000005
C 341 d0000005
I 6
O 1
I 40
O 1

// File: vlog.f
+incdir+test
source/rvvi_bridge_pkg.sv
source/retire_capture.sv
source/trace_fifo.sv
source/trace_serializer.sv
source/rvvi_trace_bridge.sv
test/tb_rvvi_trace_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_rvvi_trace_bridge -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
test -s sim.log || { echo "empty simulation log"; exit 1; }
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

// File: test/tb_rvvi_checks.svh
// Typed beat and flag compare tasks for the retirement trace bridge testbench

// One mismatching value, reported with the beat it belongs to
task automatic report_mismatch(
    input string       name,
    input logic [63:0] exp_v,
    input logic [63:0] act_v
);
    $display("error %s: expected 0x%h, got 0x%h at beat %0d", name, exp_v, act_v, beat_num);
    stop_on_failure();
endtask

// Retire beat against its expected fields
task automatic compare_retire_beat(
    input beat_kind_e         kind_exp,
    input logic [ORDER_W-1:0] order_exp,
    input logic [XLEN-1:0]    insn_exp,
    input logic [XLEN-1:0]    pc_rdata_exp,
    input logic [XLEN-1:0]    pc_wdata_exp,
    input logic               trap_exp,
    input logic               intr_exp,
    input logic [XLEN-1:0]    x_wb_exp,
    input logic [XLEN-1:0]    x_wdata_exp
);
    if (beat_kind_o !== kind_exp) report_mismatch("beat_kind_o", 64'(kind_exp), 64'(beat_kind_o));
    if (order_o !== order_exp) report_mismatch("order_o", order_exp, order_o);
    if (insn_o !== insn_exp) report_mismatch("insn_o", 64'(insn_exp), 64'(insn_o));
    if (pc_rdata_o !== pc_rdata_exp) begin
        report_mismatch("pc_rdata_o", 64'(pc_rdata_exp), 64'(pc_rdata_o));
    end
    if (pc_wdata_o !== pc_wdata_exp) begin
        report_mismatch("pc_wdata_o", 64'(pc_wdata_exp), 64'(pc_wdata_o));
    end
    if (trap_o !== trap_exp) report_mismatch("trap_o", 64'(trap_exp), 64'(trap_o));
    if (intr_o !== intr_exp) report_mismatch("intr_o", 64'(intr_exp), 64'(intr_o));
    if (x_wb_o !== x_wb_exp) report_mismatch("x_wb_o", 64'(x_wb_exp), 64'(x_wb_o));
    if (x_wdata_o !== x_wdata_exp) begin
        report_mismatch("x_wdata_o", 64'(x_wdata_exp), 64'(x_wdata_o));
    end
endtask

// CSR beat, address from the table and packed data
task automatic compare_csr_beat(
    input beat_kind_e            kind_exp,
    input logic [CSR_ADDR_W-1:0] addr_exp,
    input logic [XLEN-1:0]       data_exp
);
    if (beat_kind_o !== kind_exp) report_mismatch("beat_kind_o", 64'(kind_exp), 64'(beat_kind_o));
    if (csr_addr_o !== addr_exp) report_mismatch("csr_addr_o", 64'(addr_exp), 64'(csr_addr_o));
    if (csr_data_o !== data_exp) report_mismatch("csr_data_o", 64'(data_exp), 64'(csr_data_o));
endtask

// Single-bit status flag
task automatic compare_flag(
    input string name,
    input logic  exp_v,
    input logic  act_v
);
    if (act_v !== exp_v) report_mismatch(name, 64'(exp_v), 64'(act_v));
endtask

// File: test/tb_rvvi_trace_bridge.sv
// Testbench for the retirement trace bridge with pattern-file stimulus and beat checking
`timescale 1ns/10ps

module tb_rvvi_trace_bridge;
    import rvvi_bridge_pkg::*;

    // Parsed pattern line holds the op letter and up to 14 hex fields
    typedef logic [13:0][63:0] fields_t;
    typedef struct packed {
        logic [7:0] op;
        fields_t    f;
    } line_t;

    logic                     rvvi;
    logic                     arst_n_i;
    logic                     rvfi_valid_i;
    logic [ORDER_W-1:0]       rvfi_order_i;
    logic [XLEN-1:0]          rvfi_insn_i;
    logic [XLEN-1:0]          rvfi_pc_rdata_i;
    logic [XLEN-1:0]          rvfi_pc_wdata_i;
    logic                     rvfi_trap_i;
    logic                     rvfi_intr_i;
    logic [REG_ADDR_W-1:0]    rvfi_rd_addr_i;
    logic [XLEN-1:0]          rvfi_rd_wdata_i;
    logic [MSTATUS_RAW_W-1:0] mstatus_raw_i;
    logic [MIE_RAW_W-1:0]     mie_raw_i;
    logic [MCAUSE_RAW_W-1:0]  mcause_raw_i;
    logic [XLEN-1:0]          mscratch_i;
    logic [XLEN-1:0]          mepc_i;
    logic                     beat_valid_o;
    beat_kind_e               beat_kind_o;
    logic [ORDER_W-1:0]       order_o;
    logic [XLEN-1:0]          insn_o;
    logic [XLEN-1:0]          pc_rdata_o;
    logic [XLEN-1:0]          pc_wdata_o;
    logic                     trap_o;
    logic                     intr_o;
    logic [XLEN-1:0]          x_wb_o;
    logic [XLEN-1:0]          x_wdata_o;
    logic [CSR_ADDR_W-1:0]    csr_addr_o;
    logic [XLEN-1:0]          csr_data_o;
    logic                     overflow_o;

    line_t stim_q[$];
    line_t exp_q[$];
    int    beat_num;

    `include "tb_rvvi_checks.svh"

    rvvi_trace_bridge #(
        .FIFO_DEPTH (4)
    ) rvvi_trace_bridge_i (
        .rvvi            (rvvi),
        .arst_n_i        (arst_n_i),
        .rvfi_valid_i    (rvfi_valid_i),
        .rvfi_order_i    (rvfi_order_i),
        .rvfi_insn_i     (rvfi_insn_i),
        .rvfi_pc_rdata_i (rvfi_pc_rdata_i),
        .rvfi_pc_wdata_i (rvfi_pc_wdata_i),
        .rvfi_trap_i     (rvfi_trap_i),
        .rvfi_intr_i     (rvfi_intr_i),
        .rvfi_rd_addr_i  (rvfi_rd_addr_i),
        .rvfi_rd_wdata_i (rvfi_rd_wdata_i),
        .mstatus_raw_i   (mstatus_raw_i),
        .mie_raw_i       (mie_raw_i),
        .mcause_raw_i    (mcause_raw_i),
        .mscratch_i      (mscratch_i),
        .mepc_i          (mepc_i),
        .beat_valid_o    (beat_valid_o),
        .beat_kind_o     (beat_kind_o),
        .order_o         (order_o),
        .insn_o          (insn_o),
        .pc_rdata_o      (pc_rdata_o),
        .pc_wdata_o      (pc_wdata_o),
        .trap_o          (trap_o),
        .intr_o          (intr_o),
        .x_wb_o          (x_wb_o),
        .x_wdata_o       (x_wdata_o),
        .csr_addr_o      (csr_addr_o),
        .csr_data_o      (csr_data_o),
        .overflow_o      (overflow_o)
    );

    // 100 ns clock
    initial rvvi = 1'b0;
    always #50 rvvi = ~rvvi;

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "testbench stopped at first error");
    endtask

    //////////////////////////////////////////////////
    // Pattern file parsing
    //////////////////////////////////////////////////
    task automatic load_patterns();
        int          fd;
        int          n;
        string       text;
        logic [63:0] v [14];
        line_t       l;
        fd = $fopen("test/bridge_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n > 1 && text[0] != "#") begin
                for (int k = 0; k < 14; k++) v[k] = '0;
                case (text[0])
                    "S": n = $sscanf(text, "S %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                     v[8], v[9], v[10], v[11], v[12], v[13]) - 14;
                    "R": n = $sscanf(text, "R %h %h %h %h %h %h %h %h",
                                     v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]) - 8;
                    "C": n = $sscanf(text, "C %h %h", v[0], v[1]) - 2;
                    "I": n = $sscanf(text, "I %d", v[0]) - 1;
                    "O": n = $sscanf(text, "O %h", v[0]) - 1;
                    default: n = -1;
                endcase
                if (n != 0) begin
                    $display("malformed pattern line: %s", text);
                    stop_on_failure();
                end
                l.op = text[0];
                for (int k = 0; k < 14; k++) l.f[k] = v[k];
                // Expected beats go to the monitor and the rest drives the DUT
                if (l.op == "R" || l.op == "C") exp_q.push_back(l);
                else stim_q.push_back(l);
            end
        end
        $fclose(fd);
    endtask

    // Beat monitor samples at the falling edge where outputs are settled
    always @(negedge rvvi) begin
        if (arst_n_i && beat_valid_o) begin
            if (beat_num >= exp_q.size()) begin
                $display("a beat came out that no pattern line expects");
                stop_on_failure();
            end else if (exp_q[beat_num].op == "R") begin
                compare_retire_beat(BEAT_RETIRE, exp_q[beat_num].f[0],
                    exp_q[beat_num].f[1][XLEN-1:0], exp_q[beat_num].f[2][XLEN-1:0],
                    exp_q[beat_num].f[3][XLEN-1:0], exp_q[beat_num].f[4][0],
                    exp_q[beat_num].f[5][0], exp_q[beat_num].f[6][XLEN-1:0],
                    exp_q[beat_num].f[7][XLEN-1:0]);
            end else begin
                compare_csr_beat(BEAT_CSR, exp_q[beat_num].f[0][CSR_ADDR_W-1:0],
                    exp_q[beat_num].f[1][XLEN-1:0]);
            end
            beat_num++;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int idle;
        beat_num        = 0;
        arst_n_i        = 1'b0;
        rvfi_valid_i    = 1'b0;
        rvfi_order_i    = '0;
        rvfi_insn_i     = '0;
        rvfi_pc_rdata_i = '0;
        rvfi_pc_wdata_i = '0;
        rvfi_trap_i     = 1'b0;
        rvfi_intr_i     = 1'b0;
        rvfi_rd_addr_i  = '0;
        rvfi_rd_wdata_i = '0;
        mstatus_raw_i   = '0;
        mie_raw_i       = '0;
        mcause_raw_i    = '0;
        mscratch_i      = '0;
        mepc_i          = '0;
        load_patterns();
        repeat (5) @(posedge rvvi);
        arst_n_i <= 1'b1;

        foreach (stim_q[i]) begin
            if (stim_q[i].op == "S") begin
                @(posedge rvvi);
                rvfi_valid_i    <= stim_q[i].f[0][0];
                rvfi_order_i    <= stim_q[i].f[1];
                rvfi_insn_i     <= stim_q[i].f[2][XLEN-1:0];
                rvfi_pc_rdata_i <= stim_q[i].f[3][XLEN-1:0];
                rvfi_pc_wdata_i <= stim_q[i].f[4][XLEN-1:0];
                rvfi_trap_i     <= stim_q[i].f[5][0];
                rvfi_intr_i     <= stim_q[i].f[6][0];
                rvfi_rd_addr_i  <= stim_q[i].f[7][REG_ADDR_W-1:0];
                rvfi_rd_wdata_i <= stim_q[i].f[8][XLEN-1:0];
                mstatus_raw_i   <= stim_q[i].f[9][MSTATUS_RAW_W-1:0];
                mie_raw_i       <= stim_q[i].f[10][MIE_RAW_W-1:0];
                mcause_raw_i    <= stim_q[i].f[11][MCAUSE_RAW_W-1:0];
                mscratch_i      <= stim_q[i].f[12][XLEN-1:0];
                mepc_i          <= stim_q[i].f[13][XLEN-1:0];
            end else if (stim_q[i].op == "I") begin
                // Idle cycles keep the last CSR values
                repeat (int'(stim_q[i].f[0])) begin
                    @(posedge rvvi);
                    rvfi_valid_i <= 1'b0;
                end
            end else begin
                @(negedge rvvi);
                compare_flag("overflow_o", stim_q[i].f[0][0], overflow_o);
            end
        end

        // Each remaining beat must show within 50 cycles of the previous one
        idle = 0;
        while (beat_num < exp_q.size()) begin
            @(negedge rvvi);
            if (beat_valid_o) idle = 0;
            else idle++;
            if (idle >= 50) begin
                $display("timed out waiting for beat %0d", beat_num);
                stop_on_failure();
            end
        end
        // Quiet tail catches extra beats
        repeat (10) @(negedge rvvi);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: source/rvvi_trace_bridge.sv
// Retirement trace bridge top: capture, record FIFO and beat serializer
`timescale 1ns/10ps

module rvvi_trace_bridge #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                      rvvi,
    input  logic                                      arst_n_i,
    // Retirement port
    input  logic                                      rvfi_valid_i,
    input  logic [rvvi_bridge_pkg::ORDER_W-1:0]       rvfi_order_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]          rvfi_insn_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]          rvfi_pc_rdata_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]          rvfi_pc_wdata_i,
    input  logic                                      rvfi_trap_i,
    input  logic                                      rvfi_intr_i,
    input  logic [rvvi_bridge_pkg::REG_ADDR_W-1:0]    rvfi_rd_addr_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]          rvfi_rd_wdata_i,
    // Compact CSR state
    input  logic [rvvi_bridge_pkg::MSTATUS_RAW_W-1:0] mstatus_raw_i,
    input  logic [rvvi_bridge_pkg::MIE_RAW_W-1:0]     mie_raw_i,
    input  logic [rvvi_bridge_pkg::MCAUSE_RAW_W-1:0]  mcause_raw_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]          mscratch_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]          mepc_i,
    // Beat stream
    output logic                                      beat_valid_o,
    output rvvi_bridge_pkg::beat_kind_e               beat_kind_o,
    output logic [rvvi_bridge_pkg::ORDER_W-1:0]       order_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]          insn_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]          pc_rdata_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]          pc_wdata_o,
    output logic                                      trap_o,
    output logic                                      intr_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]          x_wb_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]          x_wdata_o,
    output logic [rvvi_bridge_pkg::CSR_ADDR_W-1:0]    csr_addr_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]          csr_data_o,
    output logic                                      overflow_o
);
    import rvvi_bridge_pkg::*;

    logic        cap_push;
    retire_rec_t cap_rec;
    logic        fifo_empty;
    retire_rec_t fifo_head;
    logic        ser_pop;

    retire_capture retire_capture_i (
        .rvvi            (rvvi),
        .arst_n_i        (arst_n_i),
        .rvfi_valid_i    (rvfi_valid_i),
        .rvfi_order_i    (rvfi_order_i),
        .rvfi_insn_i     (rvfi_insn_i),
        .rvfi_pc_rdata_i (rvfi_pc_rdata_i),
        .rvfi_pc_wdata_i (rvfi_pc_wdata_i),
        .rvfi_trap_i     (rvfi_trap_i),
        .rvfi_intr_i     (rvfi_intr_i),
        .rvfi_rd_addr_i  (rvfi_rd_addr_i),
        .rvfi_rd_wdata_i (rvfi_rd_wdata_i),
        .mstatus_raw_i   (mstatus_raw_i),
        .mie_raw_i       (mie_raw_i),
        .mcause_raw_i    (mcause_raw_i),
        .mscratch_i      (mscratch_i),
        .mepc_i          (mepc_i),
        .push_o          (cap_push),
        .rec_o           (cap_rec)
    );

    // Record buffer between capture and serializer
    trace_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) trace_fifo_i (
        .rvvi       (rvvi),
        .arst_n_i   (arst_n_i),
        .push_i     (cap_push),
        .rec_i      (cap_rec),
        .pop_i      (ser_pop),
        .empty_o    (fifo_empty),
        .head_o     (fifo_head),
        .overflow_o (overflow_o)
    );

    trace_serializer trace_serializer_i (
        .rvvi         (rvvi),
        .arst_n_i     (arst_n_i),
        .empty_i      (fifo_empty),
        .head_i       (fifo_head),
        .pop_o        (ser_pop),
        .beat_valid_o (beat_valid_o),
        .beat_kind_o  (beat_kind_o),
        .order_o      (order_o),
        .insn_o       (insn_o),
        .pc_rdata_o   (pc_rdata_o),
        .pc_wdata_o   (pc_wdata_o),
        .trap_o       (trap_o),
        .intr_o       (intr_o),
        .x_wb_o       (x_wb_o),
        .x_wdata_o    (x_wdata_o),
        .csr_addr_o   (csr_addr_o),
        .csr_data_o   (csr_data_o)
    );

endmodule

// File: source/trace_serializer.sv
// Trace serializer: turns each record into a retire beat followed by its CSR beats
`timescale 1ns/10ps

module trace_serializer (
    input  logic                                  rvvi,
    input  logic                                  arst_n_i,
    input  logic                                  empty_i,
    input  rvvi_bridge_pkg::retire_rec_t          head_i,
    output logic                                  pop_o,
    output logic                                  beat_valid_o,
    output rvvi_bridge_pkg::beat_kind_e           beat_kind_o,
    output logic [rvvi_bridge_pkg::ORDER_W-1:0]   order_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]      insn_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]      pc_rdata_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]      pc_wdata_o,
    output logic                                  trap_o,
    output logic                                  intr_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]      x_wb_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]      x_wdata_o,
    output logic [rvvi_bridge_pkg::CSR_ADDR_W-1:0] csr_addr_o,
    output logic [rvvi_bridge_pkg::XLEN-1:0]      csr_data_o
);
    import rvvi_bridge_pkg::*;

    // SER_CSR means CSR beats are still owed for the held record
    typedef enum logic {
        SER_IDLE,
        SER_CSR
    } ser_state_e;

    ser_state_e  state_q;
    retire_rec_t rec_q;
    csr_mask_t   remain_q;
    csr_mask_t   remain_next;
    csr_idx_e    csr_sel_q;
    csr_idx_e    csr_next;
    logic        valid_q;
    beat_kind_e  kind_q;

    // Pop in idle, which includes the last beat of a record
    assign pop_o = !empty_i && (state_q == SER_IDLE);

    // Lowest pending CSR goes first
    always_comb begin
        csr_next = CSR_MSTATUS;
        for (int i = NUM_CSRS - 1; i >= 0; i--) begin
            if (remain_q[i]) begin
                csr_next = csr_idx_e'(i);
            end
        end
        remain_next = remain_q & ~(csr_mask_t'(1) << csr_next);
    end

    //////////////////////////////////////////////////
    // Beat sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge rvvi or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= SER_IDLE;
            remain_q  <= '0;
            csr_sel_q <= CSR_MSTATUS;
            valid_q   <= 1'b0;
            kind_q    <= BEAT_RETIRE;
        end else if (pop_o) begin
            // Retire beat of the new record
            valid_q  <= 1'b1;
            kind_q   <= BEAT_RETIRE;
            remain_q <= head_i.csr_mask;
            state_q  <= (head_i.csr_mask != '0) ? SER_CSR : SER_IDLE;
        end else if (state_q == SER_CSR) begin
            valid_q   <= 1'b1;
            kind_q    <= BEAT_CSR;
            csr_sel_q <= csr_next;
            remain_q  <= remain_next;
            state_q   <= (remain_next != '0) ? SER_CSR : SER_IDLE;
        end else begin
            valid_q <= 1'b0;
            kind_q  <= BEAT_RETIRE;
        end
    end

    // Held record
    always_ff @(posedge rvvi) begin
        if (pop_o) begin
            rec_q <= head_i;
        end
    end

    //////////////////////////////////////////////////
    // Beat outputs
    //////////////////////////////////////////////////
    assign beat_valid_o = valid_q;
    assign beat_kind_o  = kind_q;
    assign order_o      = rec_q.order;
    assign insn_o       = rec_q.insn;
    assign pc_rdata_o   = rec_q.pc_rdata;
    assign pc_wdata_o   = rec_q.pc_wdata;
    assign trap_o       = rec_q.trap;
    assign intr_o       = rec_q.intr;
    // x0 writes are not reported
    assign x_wb_o       = (rec_q.rd_addr == '0) ? '0 :
                          ({{(XLEN-1){1'b0}}, 1'b1} << rec_q.rd_addr);
    assign x_wdata_o    = rec_q.rd_wdata;
    assign csr_addr_o   = CSR_ADDR[csr_sel_q];
    assign csr_data_o   = rec_q.csr_val[csr_sel_q];

    // CSR beats only continue a record
    a_csr_after_beat: assert property (@(posedge rvvi) disable iff (!arst_n_i)
        (beat_kind_o == BEAT_CSR) |-> $past(beat_valid_o))
        else $error("CSR beat without a preceding beat");

endmodule

// File: source/trace_fifo.sv
// Trace record buffer: circular FIFO of retirement records with sticky overflow flag
`timescale 1ns/10ps

module trace_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                         rvvi,
    input  logic                         arst_n_i,
    input  logic                         push_i,
    input  rvvi_bridge_pkg::retire_rec_t rec_i,
    input  logic                         pop_i,
    output logic                         empty_o,
    output rvvi_bridge_pkg::retire_rec_t head_o,
    output logic                         overflow_o
);
    import rvvi_bridge_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    retire_rec_t      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             overflow_q;
    logic             full;
    logic             push_ok;
    logic             pop_ok;

    assign full    = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    // Full means dropped, even with a pop in the same cycle
    assign push_ok = push_i && !full;
    assign pop_ok  = pop_i && !empty_o;

    //////////////////////////////////////////////////
    // Pointers, occupancy, overflow
    //////////////////////////////////////////////////
    always_ff @(posedge rvvi or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count_q <= count_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count_q <= count_q - 1'b1;
            end
            // Sticky until reset
            if (push_i && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge rvvi) begin
        if (push_ok) begin
            mem[wr_ptr_q] <= rec_i;
        end
    end

    assign head_o     = mem[rd_ptr_q];
    assign overflow_o = overflow_q;

    // Consumer must respect empty
    a_no_pop_empty: assert property (@(posedge rvvi) disable iff (!arst_n_i)
        !(pop_i && empty_o))
        else $error("pop while FIFO empty");

endmodule

// File: source/retire_capture.sv
// Retirement capture: packs CSRs, tracks CSR changes, registers one record per retirement
`timescale 1ns/10ps

module retire_capture (
    input  logic                                     rvvi,
    input  logic                                     arst_n_i,
    input  logic                                     rvfi_valid_i,
    input  logic [rvvi_bridge_pkg::ORDER_W-1:0]      rvfi_order_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]         rvfi_insn_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]         rvfi_pc_rdata_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]         rvfi_pc_wdata_i,
    input  logic                                     rvfi_trap_i,
    input  logic                                     rvfi_intr_i,
    input  logic [rvvi_bridge_pkg::REG_ADDR_W-1:0]   rvfi_rd_addr_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]         rvfi_rd_wdata_i,
    input  logic [rvvi_bridge_pkg::MSTATUS_RAW_W-1:0] mstatus_raw_i,
    input  logic [rvvi_bridge_pkg::MIE_RAW_W-1:0]    mie_raw_i,
    input  logic [rvvi_bridge_pkg::MCAUSE_RAW_W-1:0] mcause_raw_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]         mscratch_i,
    input  logic [rvvi_bridge_pkg::XLEN-1:0]         mepc_i,
    output logic                                     push_o,
    output rvvi_bridge_pkg::retire_rec_t             rec_o
);
    import rvvi_bridge_pkg::*;

    csr_vals_t   csr_now;
    csr_vals_t   csr_prev_q;
    csr_mask_t   changed;
    csr_mask_t   pending_q;
    logic        push_q;
    retire_rec_t rec_q;

    //////////////////////////////////////////////////
    // CSR packing
    //////////////////////////////////////////////////
    always_comb begin
        csr_now = '0;
        // mstatus raw order is tw, mprv, mpp, mpie, mie
        csr_now[CSR_MSTATUS][MSTATUS_TW_BIT]        = mstatus_raw_i[0];
        csr_now[CSR_MSTATUS][MSTATUS_MPRV_BIT]      = mstatus_raw_i[1];
        csr_now[CSR_MSTATUS][MSTATUS_MPP_LSB +: 2]  = mstatus_raw_i[3:2];
        csr_now[CSR_MSTATUS][MSTATUS_MPIE_BIT]      = mstatus_raw_i[4];
        csr_now[CSR_MSTATUS][MSTATUS_MIE_BIT]       = mstatus_raw_i[5];
        // mie raw is fast[15:0], then external, timer, software
        csr_now[CSR_MIE][MIE_FAST_LSB +: 16]        = mie_raw_i[15:0];
        csr_now[CSR_MIE][MIE_EXT_BIT]               = mie_raw_i[16];
        csr_now[CSR_MIE][MIE_TIMER_BIT]             = mie_raw_i[17];
        csr_now[CSR_MIE][MIE_SW_BIT]                = mie_raw_i[18];
        // Interrupt flag to the top bit, code stays low
        csr_now[CSR_MCAUSE][MCAUSE_IRQ_BIT]         = mcause_raw_i[6];
        csr_now[CSR_MCAUSE][MCAUSE_CODE_W-1:0]      = mcause_raw_i[MCAUSE_CODE_W-1:0];
        // Full-width CSRs pass straight
        csr_now[CSR_MSCRATCH]                       = mscratch_i;
        csr_now[CSR_MEPC]                           = mepc_i;
    end

    // Per-CSR change against last cycle
    always_comb begin
        for (int i = 0; i < NUM_CSRS; i++) begin
            changed[i] = (csr_now[i] != csr_prev_q[i]);
        end
    end

    //////////////////////////////////////////////////
    // Change tracking and push strobe
    //////////////////////////////////////////////////
    always_ff @(posedge rvvi or negedge arst_n_i) begin
        if (!arst_n_i) begin
            csr_prev_q <= '0;
            pending_q  <= '0;
            push_q     <= 1'b0;
        end else begin
            csr_prev_q <= csr_now;
            push_q     <= rvfi_valid_i;
            // Retirement consumes the mask
            if (rvfi_valid_i) begin
                pending_q <= '0;
            end else begin
                pending_q <= pending_q | changed;
            end
        end
    end

    // Record payload, loaded on retirement only
    always_ff @(posedge rvvi) begin
        if (rvfi_valid_i) begin
            rec_q.order    <= rvfi_order_i;
            rec_q.insn     <= rvfi_insn_i;
            rec_q.pc_rdata <= rvfi_pc_rdata_i;
            rec_q.pc_wdata <= rvfi_pc_wdata_i;
            rec_q.trap     <= rvfi_trap_i;
            rec_q.intr     <= rvfi_intr_i;
            rec_q.rd_addr  <= rvfi_rd_addr_i;
            rec_q.rd_wdata <= rvfi_rd_wdata_i;
            rec_q.csr_val  <= csr_now;
            // Same-cycle change counts too
            rec_q.csr_mask <= pending_q | changed;
        end
    end

    assign push_o = push_q;
    assign rec_o  = rec_q;

    // Back-to-back pushes need back-to-back retirements
    a_push_follows_valid: assert property (@(posedge rvvi) disable iff (!arst_n_i)
        (push_o && $past(push_o)) |-> ($past(rvfi_valid_i, 1) && $past(rvfi_valid_i, 2)))
        else $error("push_o held without consecutive retirements");

endmodule

// File: source/rvvi_bridge_pkg.sv
// Retirement trace bridge package with widths, CSR table, enums and record layout
package rvvi_bridge_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int XLEN         = 32;
    localparam int ORDER_W      = 64;
    localparam int CSR_ADDR_W   = 12;
    localparam int NUM_CSRS     = 5;
    localparam int REG_ADDR_W   = 5;
    // Compact CSR fields as the core keeps them
    localparam int MSTATUS_RAW_W = 6;
    localparam int MIE_RAW_W     = 19;
    localparam int MCAUSE_RAW_W  = 7;

    // Tracked CSRs, in serialization order
    typedef enum logic [2:0] {
        CSR_MSTATUS,
        CSR_MIE,
        CSR_MCAUSE,
        CSR_MSCRATCH,
        CSR_MEPC
    } csr_idx_e;

    // Address per csr_idx_e, index 0 is mstatus
    localparam logic [NUM_CSRS-1:0][CSR_ADDR_W-1:0] CSR_ADDR =
        {12'h341, 12'h340, 12'h342, 12'h304, 12'h300};

    typedef enum logic {
        BEAT_RETIRE,
        BEAT_CSR
    } beat_kind_e;

    typedef logic [NUM_CSRS-1:0]           csr_mask_t;
    typedef logic [NUM_CSRS-1:0][XLEN-1:0] csr_vals_t;

    //////////////////////////////////////////////////
    // Architectural bit positions
    //////////////////////////////////////////////////
    localparam int MSTATUS_TW_BIT   = 21;
    localparam int MSTATUS_MPRV_BIT = 17;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MIE_FAST_LSB     = 16;
    localparam int MIE_EXT_BIT      = 11;
    localparam int MIE_TIMER_BIT    = 7;
    localparam int MIE_SW_BIT       = 3;
    localparam int MCAUSE_IRQ_BIT   = 31;
    localparam int MCAUSE_CODE_W    = 6;

    // One retirement plus the CSR state that goes with it
    typedef struct packed {
        logic [ORDER_W-1:0]    order;
        logic [XLEN-1:0]       insn;
        logic [XLEN-1:0]       pc_rdata;
        logic [XLEN-1:0]       pc_wdata;
        logic                  trap;
        logic                  intr;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       rd_wdata;
        csr_vals_t             csr_val;
        csr_mask_t             csr_mask;
    } retire_rec_t;

endpackage
